// File: Bender.yml
package:
  name: bt_bridge

sources:
  - src/bt_bridge_pkg.sv
  - src/sync_fifo.sv
  - src/uart_tx.sv
  - src/uart_rx.sv
  - src/stream_sender.sv
  - src/response_receiver.sv
  - src/bridge_controller.sv
  - src/bt_bridge_top.sv
  - target: test
    files:
      - tb/bt_bridge_asserts.sv
      - tb/tb_bt_bridge.sv

// File: src/bridge_controller.sv
/*
	Bridge controller FSM and UART transmitter
	Stream words go out as two frames, low byte first, then a gap
	AT exchanges send the queued bytes and wait for the reply
*/

`timescale 1ns/1ps
`default_nettype none

module bridge_controller import bt_bridge_pkg::*; #(
	parameter int CYCLES_PER_BIT = 8,
	parameter int GAP_CYCLES = 4
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              word_avail,
	input  logic [WORD_W-1:0] word,
	input  logic              at_avail,
	input  logic [BYTE_W-1:0] at_byte,
	input  logic              reply_done,
	input  logic              at_start,
	output logic              word_pop,
	output logic              at_pop,
	output logic              txd,
	output logic              at_busy
);

	localparam int GAP_W = (GAP_CYCLES > 1) ? $clog2(GAP_CYCLES) : 1;
	localparam logic [GAP_W-1:0] LAST_GAP = GAP_W'(GAP_CYCLES - 1);

	ctrl_state_t state;
	ctrl_state_t state_next;
	logic [WORD_W-1:0] word_hold;
	logic [GAP_W-1:0] gap_count;
	logic [BYTE_W-1:0] tx_data;
	logic tx_start;
	logic tx_done;
	logic tx_active;

	always_comb
	begin
		state_next = state;
		tx_start = 1'b0;
		tx_data = word_hold[BYTE_W-1:0];
		word_pop = 1'b0;
		at_pop = 1'b0;
		case (state)
			IDLE:
			begin
				// AT exchange wins over waiting stream words
				if (at_start)
					state_next = AT_SEND;
				else if (word_avail)
					state_next = PICK;
			end
			PICK:
			begin
				word_pop = 1'b1;
				tx_start = 1'b1;
				tx_data = word[BYTE_W-1:0];
				state_next = SEND_LOW;
			end
			SEND_LOW:
			begin
				if (tx_done)
				begin
					tx_start = 1'b1;
					tx_data = word_hold[WORD_W-1:BYTE_W];
					state_next = SEND_HIGH;
				end
			end
			SEND_HIGH:
			begin
				if (tx_done)
					state_next = GAP;
			end
			GAP:
			begin
				if (gap_count == LAST_GAP)
					state_next = IDLE;
			end
			AT_SEND:
			begin
				// Next byte as soon as the line is free
				if (!tx_active || tx_done)
				begin
					if (at_avail)
					begin
						tx_start = 1'b1;
						tx_data = at_byte;
						at_pop = 1'b1;
					end
					else
						state_next = AT_WAIT;
				end
			end
			AT_WAIT:
			begin
				if (reply_done)
					state_next = IDLE;
			end
			default:
				state_next = IDLE;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= IDLE;
			gap_count <= '0;
			tx_active <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if ((state == GAP) && (state_next == GAP))
				gap_count <= gap_count + 1'b1;
			else
				gap_count <= '0;
			if (tx_start)
				tx_active <= 1'b1;
			else if (tx_done)
				tx_active <= 1'b0;
		end
	end

	// High byte kept for the second frame
	always_ff @(posedge clock)
	begin
		if (word_pop)
			word_hold <= word;
	end

	assign at_busy = (state == AT_SEND) || (state == AT_WAIT);

	uart_tx #(
		.CYCLES_PER_BIT(CYCLES_PER_BIT)
	) u_tx (
		.clock(clock),
		.reset(reset),
		.start(tx_start),
		.data(tx_data),
		.txd(txd),
		.done(tx_done)
	);

endmodule

`default_nettype wire

// File: src/bt_bridge_pkg.sv
/*
	Shared constants for the sensor stream to Bluetooth UART bridge
	Word and byte widths, AT reply terminator, controller state encoding
*/

`default_nettype none

package bt_bridge_pkg;

	// Sensor stream word and UART payload widths
	localparam int WORD_W = 16;
	localparam int BYTE_W = 8;

	// Byte that closes every AT reply from the module
	localparam logic [BYTE_W-1:0] LINE_FEED = 8'h0A;

	// Bridge controller states
	typedef enum logic [2:0] {
		IDLE,
		PICK,
		SEND_LOW,
		SEND_HIGH,
		GAP,
		AT_SEND,
		AT_WAIT
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: src/bt_bridge_top.sv
/*
	Sensor stream to Bluetooth UART bridge, top level
	Stream sender, response receiver and bridge controller
*/

`timescale 1ns/1ps
`default_nettype none

module bt_bridge_top import bt_bridge_pkg::*; #(
	parameter int NUM_STREAMS = 4,
	parameter int FIFO_DEPTH = 8,
	parameter int CYCLES_PER_BIT = 8,
	parameter int GAP_CYCLES = 4
) (
	input  logic                               clock,
	input  logic                               reset,
	input  logic [NUM_STREAMS-1:0][WORD_W-1:0] stream_data,
	input  logic [NUM_STREAMS-1:0]             stream_valid,
	input  logic                               at_write,
	input  logic [BYTE_W-1:0]                  at_data,
	input  logic                               at_start,
	input  logic                               resp_read,
	input  logic                               rxd,
	output logic                               txd,
	output logic [NUM_STREAMS-1:0]             stream_full,
	output logic [BYTE_W-1:0]                  resp_data,
	output logic                               resp_empty,
	output logic                               at_busy
);

	logic word_avail;
	logic [WORD_W-1:0] word;
	logic at_avail;
	logic [BYTE_W-1:0] at_byte;
	logic word_pop;
	logic at_pop;
	logic reply_done;

	stream_sender #(
		.NUM_STREAMS(NUM_STREAMS),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_sender (
		.clock(clock),
		.reset(reset),
		.stream_data(stream_data),
		.stream_valid(stream_valid),
		.stream_full(stream_full),
		.at_write(at_write),
		.at_data(at_data),
		.word_pop(word_pop),
		.at_pop(at_pop),
		.word_avail(word_avail),
		.word(word),
		.at_avail(at_avail),
		.at_byte(at_byte)
	);

	response_receiver #(
		.CYCLES_PER_BIT(CYCLES_PER_BIT),
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_receiver (
		.clock(clock),
		.reset(reset),
		.rxd(rxd),
		.resp_read(resp_read),
		.resp_data(resp_data),
		.resp_empty(resp_empty),
		.reply_done(reply_done)
	);

	bridge_controller #(
		.CYCLES_PER_BIT(CYCLES_PER_BIT),
		.GAP_CYCLES(GAP_CYCLES)
	) u_controller (
		.clock(clock),
		.reset(reset),
		.word_avail(word_avail),
		.word(word),
		.at_avail(at_avail),
		.at_byte(at_byte),
		.reply_done(reply_done),
		.at_start(at_start),
		.word_pop(word_pop),
		.at_pop(at_pop),
		.txd(txd),
		.at_busy(at_busy)
	);

endmodule

`default_nettype wire

// File: src/response_receiver.sv
/*
	Incoming side of the bridge
	UART receiver into the response FIFO, end-of-reply pulse on line feed
*/

`timescale 1ns/1ps
`default_nettype none

module response_receiver import bt_bridge_pkg::*; #(
	parameter int CYCLES_PER_BIT = 8,
	parameter int FIFO_DEPTH = 8
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              rxd,
	input  logic              resp_read,
	output logic [BYTE_W-1:0] resp_data,
	output logic              resp_empty,
	output logic              reply_done
);

	logic [BYTE_W-1:0] rx_data;
	logic rx_valid;

	uart_rx #(
		.CYCLES_PER_BIT(CYCLES_PER_BIT)
	) u_rx (
		.clock(clock),
		.reset(reset),
		.rxd(rxd),
		.data(rx_data),
		.data_valid(rx_valid)
	);

	sync_fifo #(
		.WIDTH(BYTE_W),
		.DEPTH(FIFO_DEPTH)
	) u_resp_fifo (
		.clock(clock),
		.reset(reset),
		.push(rx_valid),
		.push_data(rx_data),
		.pop(resp_read),
		.pop_data(resp_data),
		.full(),
		.empty(resp_empty)
	);

	// Lines up with the cycle the LF byte becomes visible in the FIFO
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			reply_done <= 1'b0;
		else
			reply_done <= rx_valid && (rx_data == LINE_FEED);
	end

endmodule

`default_nettype wire

// File: src/stream_sender.sv
/*
	Outgoing side of the bridge
	One FIFO per sensor stream, the AT command FIFO,
	and a round-robin selector over the non-empty streams
*/

`timescale 1ns/1ps
`default_nettype none

module stream_sender import bt_bridge_pkg::*; #(
	parameter int NUM_STREAMS = 4,
	parameter int FIFO_DEPTH = 8
) (
	input  logic                               clock,
	input  logic                               reset,
	input  logic [NUM_STREAMS-1:0][WORD_W-1:0] stream_data,
	input  logic [NUM_STREAMS-1:0]             stream_valid,
	output logic [NUM_STREAMS-1:0]             stream_full,
	input  logic                               at_write,
	input  logic [BYTE_W-1:0]                  at_data,
	input  logic                               word_pop,
	input  logic                               at_pop,
	output logic                               word_avail,
	output logic [WORD_W-1:0]                  word,
	output logic                               at_avail,
	output logic [BYTE_W-1:0]                  at_byte
);

	localparam int SEL_W = (NUM_STREAMS > 1) ? $clog2(NUM_STREAMS) : 1;
	localparam logic [SEL_W-1:0] LAST_STREAM = SEL_W'(NUM_STREAMS - 1);

	logic [NUM_STREAMS-1:0][WORD_W-1:0] head;
	logic [NUM_STREAMS-1:0] empty;
	logic [NUM_STREAMS-1:0] pop_sel;
	logic [SEL_W-1:0] last_served;
	logic [SEL_W-1:0] selected;
	logic [SEL_W-1:0] candidate;
	logic found;
	logic at_empty;

	for (genvar i = 0; i < NUM_STREAMS; i++)
	begin : g_stream
		assign pop_sel[i] = word_pop && (selected == SEL_W'(i));

		sync_fifo #(
			.WIDTH(WORD_W),
			.DEPTH(FIFO_DEPTH)
		) u_fifo (
			.clock(clock),
			.reset(reset),
			.push(stream_valid[i]),
			.push_data(stream_data[i]),
			.pop(pop_sel[i]),
			.pop_data(head[i]),
			.full(stream_full[i]),
			.empty(empty[i])
		);
	end

	sync_fifo #(
		.WIDTH(BYTE_W),
		.DEPTH(FIFO_DEPTH)
	) u_at_fifo (
		.clock(clock),
		.reset(reset),
		.push(at_write),
		.push_data(at_data),
		.pop(at_pop),
		.pop_data(at_byte),
		.full(),
		.empty(at_empty)
	);

	// Scan from the stream after the last one served, wrapping around
	always_comb
	begin
		selected = last_served;
		candidate = last_served;
		found = 1'b0;
		for (int i = 0; i < NUM_STREAMS; i++)
		begin
			candidate = (candidate == LAST_STREAM) ? '0 : candidate + 1'b1;
			if (!found && !empty[candidate])
			begin
				selected = candidate;
				found = 1'b1;
			end
		end
	end

	// Starts at the last stream so stream 0 goes first after reset
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			last_served <= LAST_STREAM;
		else if (word_pop)
			last_served <= selected;
	end

	assign word_avail = !(&empty);
	assign word = head[selected];
	assign at_avail = !at_empty;

endmodule

`default_nettype wire

// File: src/sync_fifo.sv
/*
	Single-clock FIFO, first-word fall-through
	Circular buffer with occupancy count, full and empty flags
*/

`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 8
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             push,
	input  logic [WIDTH-1:0] push_data,
	input  logic             pop,
	output logic [WIDTH-1:0] pop_data,
	output logic             full,
	output logic             empty
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int COUNT_W = PTR_W + 1;
	localparam logic [COUNT_W-1:0] FULL_COUNT = COUNT_W'(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [COUNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	// Push while full and pop while empty are dropped
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	assign full = (count == FULL_COUNT);
	assign empty = (count == '0);
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clock)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			// Pointers wrap naturally, depth is a power of two
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + COUNT_W'(do_push) - COUNT_W'(do_pop);
		end
	end

endmodule

`default_nettype wire

// File: src/uart_rx.sv
/*
	8N1 UART receiver
	Two-flop input synchronizer, start edge detect, mid-bit sampling
	Frames with a low stop bit are dropped
*/

`timescale 1ns/1ps
`default_nettype none

module uart_rx import bt_bridge_pkg::*; #(
	parameter int CYCLES_PER_BIT = 8
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              rxd,
	output logic [BYTE_W-1:0] data,
	output logic              data_valid
);

	localparam int CNT_W = (CYCLES_PER_BIT > 1) ? $clog2(CYCLES_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] LAST_CYCLE = CNT_W'(CYCLES_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_CYCLE = CNT_W'(CYCLES_PER_BIT / 2 - 1);
	localparam logic [3:0] STOP_INDEX = 4'(BYTE_W + 1);

	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic busy;
	logic sample;
	logic [3:0] bit_index;
	logic [CNT_W-1:0] cycle_count;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end
		else
		begin
			rx_meta <= rxd;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// Half a bit into the start bit, then one full bit per sample
	assign sample = busy && (((bit_index == '0) && (cycle_count == HALF_CYCLE)) ||
		((bit_index != '0) && (cycle_count == LAST_CYCLE)));

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			bit_index <= '0;
			cycle_count <= '0;
			data_valid <= 1'b0;
		end
		else
		begin
			data_valid <= 1'b0;
			if (!busy)
			begin
				cycle_count <= '0;
				bit_index <= '0;
				if (rx_prev && !rx_sync)
					busy <= 1'b1;
			end
			else if (sample)
			begin
				cycle_count <= '0;
				if (bit_index == '0)
				begin
					// Start bit gone high again, treat as a glitch
					if (rx_sync)
						busy <= 1'b0;
					else
						bit_index <= 4'd1;
				end
				else if (bit_index == STOP_INDEX)
				begin
					busy <= 1'b0;
					data_valid <= rx_sync;
				end
				else
					bit_index <= bit_index + 1'b1;
			end
			else
				cycle_count <= cycle_count + 1'b1;
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clock)
	begin
		if (sample && (bit_index != '0) && (bit_index != STOP_INDEX))
			data <= {rx_sync, data[BYTE_W-1:1]};
	end

endmodule

`default_nettype wire

// File: src/uart_tx.sv
/*
	8N1 UART transmitter
	Start pulse loads a frame, done pulses once the stop bit has ended
*/

`timescale 1ns/1ps
`default_nettype none

module uart_tx import bt_bridge_pkg::*; #(
	parameter int CYCLES_PER_BIT = 8
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              start,
	input  logic [BYTE_W-1:0] data,
	output logic              txd,
	output logic              done
);

	localparam int CNT_W = (CYCLES_PER_BIT > 1) ? $clog2(CYCLES_PER_BIT) : 1;
	localparam logic [CNT_W-1:0] LAST_CYCLE = CNT_W'(CYCLES_PER_BIT - 1);
	localparam logic [3:0] LAST_BIT = 4'(BYTE_W + 1);

	// Start bit at the bottom, stop bit at the top
	logic [BYTE_W+1:0] frame;
	logic [CNT_W-1:0] cycle_count;
	logic [3:0] bits_left;
	logic busy;

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			frame <= '1;
			cycle_count <= '0;
			bits_left <= '0;
			busy <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (!busy)
			begin
				// Start requests during a frame are ignored
				if (start)
				begin
					frame <= {1'b1, data, 1'b0};
					cycle_count <= '0;
					bits_left <= LAST_BIT;
					busy <= 1'b1;
				end
			end
			else if (cycle_count == LAST_CYCLE)
			begin
				cycle_count <= '0;
				frame <= {1'b1, frame[BYTE_W+1:1]};
				if (bits_left == '0)
				begin
					busy <= 1'b0;
					done <= 1'b1;
				end
				else
					bits_left <= bits_left - 1'b1;
			end
			else
				cycle_count <= cycle_count + 1'b1;
		end
	end

	// Fill with ones keeps the line idle high between frames
	assign txd = frame[0];

endmodule

`default_nettype wire

// File: tb.f
src/bt_bridge_pkg.sv
src/sync_fifo.sv
src/uart_tx.sv
src/uart_rx.sv
src/stream_sender.sv
src/response_receiver.sv
src/bridge_controller.sv
src/bt_bridge_top.sv
tb/bt_bridge_asserts.sv
tb/tb_bt_bridge.sv

// File: tb/bt_bridge_asserts.sv
/*
	Concurrent assertions bound into the bridge controller and the FIFOs
	Pop exclusivity, no pop of an empty FIFO, at_busy release on reply
*/

`timescale 1ns/1ps
`default_nettype none

module bt_bridge_asserts (
	input logic clock,
	input logic reset,
	input logic word_pop,
	input logic at_pop,
	input logic reply_done,
	input logic at_busy,
	input logic fifo_pop,
	input logic fifo_empty
);

	a_pop_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(word_pop && at_pop))
		else $error("word_pop and at_pop asserted together");

	a_pop_nonempty: assert property (@(posedge clock) disable iff (reset)
		fifo_pop |-> !fifo_empty)
		else $error("pop while the FIFO is empty");

	a_busy_release: assert property (@(posedge clock) disable iff (reset)
		$fell(at_busy) |-> $past(reply_done))
		else $error("at_busy dropped without reply_done");

endmodule

// Controller strobes and the AT busy level
bind bridge_controller bt_bridge_asserts u_asserts (
	.clock(clock),
	.reset(reset),
	.word_pop(word_pop),
	.at_pop(at_pop),
	.reply_done(reply_done),
	.at_busy(at_busy),
	.fifo_pop(1'b0),
	.fifo_empty(1'b0)
);

// Pop requests arriving at every stream, AT and response FIFO
bind sync_fifo bt_bridge_asserts u_asserts (
	.clock(clock),
	.reset(reset),
	.word_pop(1'b0),
	.at_pop(1'b0),
	.reply_done(1'b0),
	.at_busy(1'b0),
	.fifo_pop(pop),
	.fifo_empty(empty)
);

`default_nettype wire

// File: tb/tb_bt_bridge.sv
/*
	Testbench for the sensor stream to Bluetooth UART bridge
	Stimulus table, txd monitor, rxd reply driver, checks and report
*/

`timescale 1ns/1ps
`default_nettype none

module tb_bt_bridge import bt_bridge_pkg::*;;

	localparam int NUM_STREAMS = 4;
	localparam int FIFO_DEPTH = 8;
	localparam int CYCLES_PER_BIT = 8;
	localparam int GAP_CYCLES = 4;

	localparam int NUM_ENTRIES = 5;
	localparam int MAX_PUSH = 16;
	localparam int MAX_AT = 4;
	localparam int MAX_BYTES = 32;
	localparam int MODE_STREAM = 0;
	localparam int MODE_AT = 1;
	localparam int MODE_BLOCKED = 2;
	localparam int SETTLE_CYCLES = 30 * CYCLES_PER_BIT;

	logic clock;
	logic reset;
	logic [NUM_STREAMS-1:0][WORD_W-1:0] stream_data;
	logic [NUM_STREAMS-1:0] stream_valid;
	logic at_write;
	logic [BYTE_W-1:0] at_data;
	logic at_start;
	logic resp_read;
	logic rxd;
	logic txd;
	logic [NUM_STREAMS-1:0] stream_full;
	logic [BYTE_W-1:0] resp_data;
	logic resp_empty;
	logic at_busy;

	// Stimulus table, one row per test
	int t_mode [NUM_ENTRIES];
	int t_push_count [NUM_ENTRIES];
	int t_push_beat [NUM_ENTRIES][MAX_PUSH];
	int t_push_stream [NUM_ENTRIES][MAX_PUSH];
	logic [WORD_W-1:0] t_push_word [NUM_ENTRIES][MAX_PUSH];
	int t_at_count [NUM_ENTRIES];
	logic [BYTE_W-1:0] t_at_byte [NUM_ENTRIES][MAX_AT];
	logic [NUM_STREAMS-1:0] t_full_mask [NUM_ENTRIES];
	int t_exp_count [NUM_ENTRIES];
	logic [BYTE_W-1:0] t_exp_byte [NUM_ENTRIES][MAX_BYTES];

	logic [BYTE_W-1:0] mon_q [$];
	logic [BYTE_W-1:0] reply_bytes [8];
	int reply_len;
	int error_count;
	int tests_failed;
	int current_test;
	integer seed;

	bt_bridge_top #(
		.NUM_STREAMS(NUM_STREAMS),
		.FIFO_DEPTH(FIFO_DEPTH),
		.CYCLES_PER_BIT(CYCLES_PER_BIT),
		.GAP_CYCLES(GAP_CYCLES)
	) dut (
		.clock(clock),
		.reset(reset),
		.stream_data(stream_data),
		.stream_valid(stream_valid),
		.at_write(at_write),
		.at_data(at_data),
		.at_start(at_start),
		.resp_read(resp_read),
		.rxd(rxd),
		.txd(txd),
		.stream_full(stream_full),
		.resp_data(resp_data),
		.resp_empty(resp_empty),
		.at_busy(at_busy)
	);

	initial
	begin
		clock = 1'b0;
		forever
			#50 clock = ~clock;
	end

	// Decodes txd frames, sampling near the middle of each bit
	initial
	begin : txd_monitor
		logic [BYTE_W-1:0] shift;
		int k;
		forever
		begin
			@(negedge clock);
			if (!reset && !txd)
			begin
				repeat (CYCLES_PER_BIT / 2) @(negedge clock);
				if (txd !== 1'b0)
				begin
					error_count++;
					$display("ERROR %0t: start bit on txd did not stay low", $time);
				end
				for (k = 0; k < BYTE_W; k++)
				begin
					repeat (CYCLES_PER_BIT) @(negedge clock);
					shift[k] = txd;
				end
				repeat (CYCLES_PER_BIT) @(negedge clock);
				if (txd !== 1'b1)
				begin
					error_count++;
					$display("ERROR %0t: stop bit on txd is low", $time);
				end
				mon_q.push_back(shift);
			end
		end
	end

	task automatic report_value(input string what, input logic [31:0] expected,
		input logic [31:0] got);
		error_count++;
		$display("ERROR %0t: test %0d %s expected %0h got %0h", $time, current_test, what,
			expected, got);
	endtask

	task automatic add_push(input int e, input int beat, input int stream,
		input logic [WORD_W-1:0] w);
		t_push_beat[e][t_push_count[e]] = beat;
		t_push_stream[e][t_push_count[e]] = stream;
		t_push_word[e][t_push_count[e]] = w;
		t_push_count[e]++;
	endtask

	// Low byte goes out first
	task automatic expect_word(input int e, input logic [WORD_W-1:0] w);
		t_exp_byte[e][t_exp_count[e]] = w[7:0];
		t_exp_byte[e][t_exp_count[e] + 1] = w[15:8];
		t_exp_count[e] += 2;
	endtask

	task automatic add_at_byte(input int e, input logic [BYTE_W-1:0] b);
		t_at_byte[e][t_at_count[e]] = b;
		t_at_count[e]++;
		t_exp_byte[e][t_exp_count[e]] = b;
		t_exp_count[e]++;
	endtask

	task automatic load_table();
		int e;
		int k;
		for (e = 0; e < NUM_ENTRIES; e++)
		begin
			t_push_count[e] = 0;
			t_at_count[e] = 0;
			t_exp_count[e] = 0;
			t_full_mask[e] = '0;
		end
		// Single word, stream 2
		t_mode[0] = MODE_STREAM;
		add_push(0, 0, 2, 16'hA55A);
		expect_word(0, 16'hA55A);
		// Three streams, round robin continues after stream 2
		t_mode[1] = MODE_STREAM;
		add_push(1, 0, 0, 16'h1101);
		add_push(1, 0, 1, 16'h2201);
		add_push(1, 0, 3, 16'h4401);
		add_push(1, 1, 0, 16'h1102);
		add_push(1, 1, 3, 16'h4402);
		expect_word(1, 16'h4401);
		expect_word(1, 16'h1101);
		expect_word(1, 16'h2201);
		expect_word(1, 16'h4402);
		expect_word(1, 16'h1102);
		// Plain AT exchange
		t_mode[2] = MODE_AT;
		add_at_byte(2, 8'h41);
		add_at_byte(2, 8'h54);
		add_at_byte(2, 8'h0D);
		add_at_byte(2, 8'h0A);
		// Overflow stream 1 while the AT exchange blocks the line
		t_mode[3] = MODE_BLOCKED;
		add_at_byte(3, 8'h41);
		add_at_byte(3, 8'h54);
		for (k = 0; k < FIFO_DEPTH + 2; k++)
			add_push(3, k, 1, 16'h3100 + 16'(k));
		for (k = 0; k < FIFO_DEPTH; k++)
			expect_word(3, 16'h3100 + 16'(k));
		t_full_mask[3] = 4'b0010;
		// Several streams held back during AT, stream 1 served last
		t_mode[4] = MODE_BLOCKED;
		add_at_byte(4, 8'h49);
		add_push(4, 0, 0, 16'h5001);
		add_push(4, 0, 2, 16'h5201);
		add_push(4, 1, 0, 16'h5002);
		add_push(4, 1, 3, 16'h5301);
		expect_word(4, 16'h5201);
		expect_word(4, 16'h5301);
		expect_word(4, 16'h5001);
		expect_word(4, 16'h5002);
	endtask

	function automatic string mode_name(input int mode);
		if (mode == MODE_STREAM)
			return "stream";
		else if (mode == MODE_AT)
			return "at exchange";
		else
			return "stream during at";
	endfunction

	task automatic apply_pushes(input int e);
		int beat;
		int last_beat;
		int k;
		last_beat = -1;
		for (k = 0; k < t_push_count[e]; k++)
			if (t_push_beat[e][k] > last_beat)
				last_beat = t_push_beat[e][k];
		for (beat = 0; beat <= last_beat; beat++)
		begin
			@(negedge clock);
			stream_valid = '0;
			for (k = 0; k < t_push_count[e]; k++)
			begin
				if (t_push_beat[e][k] == beat)
				begin
					stream_valid[t_push_stream[e][k]] = 1'b1;
					stream_data[t_push_stream[e][k]] = t_push_word[e][k];
				end
			end
		end
		@(negedge clock);
		stream_valid = '0;
	endtask

	task automatic start_at(input int e);
		int k;
		for (k = 0; k < t_at_count[e]; k++)
		begin
			@(negedge clock);
			at_write = 1'b1;
			at_data = t_at_byte[e][k];
		end
		@(negedge clock);
		at_write = 1'b0;
		at_start = 1'b1;
		@(negedge clock);
		at_start = 1'b0;
		if (at_busy !== 1'b1)
			report_value("at_busy after at_start", 1, at_busy);
	endtask

	task automatic drive_rx_byte(input logic [BYTE_W-1:0] b);
		int k;
		@(negedge clock);
		rxd = 1'b0;
		repeat (CYCLES_PER_BIT) @(negedge clock);
		for (k = 0; k < BYTE_W; k++)
		begin
			rxd = b[k];
			repeat (CYCLES_PER_BIT) @(negedge clock);
		end
		rxd = 1'b1;
		repeat (CYCLES_PER_BIT) @(negedge clock);
	endtask

	// Random body without LF, then the LF terminator
	task automatic send_reply();
		logic [31:0] rnd;
		int k;
		rnd = $random(seed);
		reply_len = 2 + int'(rnd[7:0] % 8'd6);
		for (k = 0; k < reply_len - 1; k++)
		begin
			rnd = $random(seed);
			reply_bytes[k] = (rnd[7:0] == LINE_FEED) ? 8'h55 : rnd[7:0];
		end
		reply_bytes[reply_len - 1] = LINE_FEED;
		for (k = 0; k < reply_len; k++)
			drive_rx_byte(reply_bytes[k]);
	endtask

	task automatic wait_bytes(input int count);
		int cycles;
		cycles = 0;
		while ((mon_q.size() < count) && (cycles < count * 12 * CYCLES_PER_BIT + 100))
		begin
			@(negedge clock);
			cycles++;
		end
		if (mon_q.size() < count)
		begin
			error_count++;
			$display("Timeout in test %0d: only %0d of %0d bytes arrived on txd",
				current_test, mon_q.size(), count);
		end
	endtask

	task automatic wait_busy_low();
		int cycles;
		cycles = 0;
		while ((at_busy !== 1'b0) && (cycles < 20 * CYCLES_PER_BIT))
		begin
			@(negedge clock);
			cycles++;
		end
		if (at_busy !== 1'b0)
		begin
			error_count++;
			$display("Timeout in test %0d: at_busy stayed high after the reply", current_test);
		end
	endtask

	task automatic read_responses();
		int count;
		count = 0;
		@(negedge clock);
		while (!resp_empty && (count < 2 * FIFO_DEPTH))
		begin
			if ((count < reply_len) && (resp_data !== reply_bytes[count]))
				report_value($sformatf("response byte %0d", count), reply_bytes[count],
					resp_data);
			resp_read = 1'b1;
			count++;
			@(negedge clock);
			resp_read = 1'b0;
		end
		if (count != reply_len)
			report_value("response byte count", reply_len, count);
	endtask

	task automatic run_entry(input int e);
		int errs_before;
		int k;
		errs_before = error_count;
		current_test = e + 1;
		mon_q.delete();
		if (t_mode[e] != MODE_STREAM)
		begin
			start_at(e);
			wait_bytes(t_at_count[e]);
		end
		apply_pushes(e);
		if (t_mode[e] == MODE_BLOCKED)
		begin
			if (stream_full !== t_full_mask[e])
				report_value("stream_full while blocked", t_full_mask[e], stream_full);
			if (mon_q.size() != t_at_count[e])
				report_value("bytes on txd while at_busy", t_at_count[e], mon_q.size());
		end
		if (t_mode[e] != MODE_STREAM)
		begin
			if (at_busy !== 1'b1)
				report_value("at_busy before reply", 1, at_busy);
			send_reply();
			wait_busy_low();
			if (mon_q.size() != t_at_count[e])
				report_value("bytes on txd when at_busy fell", t_at_count[e], mon_q.size());
			read_responses();
		end
		wait_bytes(t_exp_count[e]);
		repeat (SETTLE_CYCLES) @(negedge clock);
		if (mon_q.size() != t_exp_count[e])
			report_value("txd byte count", t_exp_count[e], mon_q.size());
		for (k = 0; (k < t_exp_count[e]) && (k < mon_q.size()); k++)
			if (mon_q[k] !== t_exp_byte[e][k])
				report_value($sformatf("txd byte %0d", k), t_exp_byte[e][k], mon_q[k]);
		if (stream_full !== '0)
			report_value("stream_full after drain", 0, stream_full);
		if (error_count != errs_before)
			tests_failed++;
		$display("test %0d %s: %s", current_test, mode_name(t_mode[e]),
			(error_count == errs_before) ? "ok" : "FAIL");
	endtask

	initial
	begin
		int e;
		$timeformat(-9, 0, " ns", 0);
		seed = 51126;
		error_count = 0;
		tests_failed = 0;
		current_test = 0;
		reset = 1'b1;
		stream_data = '0;
		stream_valid = '0;
		at_write = 1'b0;
		at_data = '0;
		at_start = 1'b0;
		resp_read = 1'b0;
		rxd = 1'b1;
		load_table();
		repeat (16) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);

		// Idle levels straight out of reset
		if (txd !== 1'b1)
			report_value("txd after reset", 1, txd);
		if (at_busy !== 1'b0)
			report_value("at_busy after reset", 0, at_busy);
		if (resp_empty !== 1'b1)
			report_value("resp_empty after reset", 1, resp_empty);
		if (stream_full !== '0)
			report_value("stream_full after reset", 0, stream_full);
		if (error_count != 0)
			tests_failed++;
		$display("test 0 reset state: %s", (error_count == 0) ? "ok" : "FAIL");

		for (e = 0; e < NUM_ENTRIES; e++)
			run_entry(e);

		$display("tests %0d, failed %0d, errors %0d", NUM_ENTRIES + 1, tests_failed,
			error_count);
		if (error_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire
